//--- filelist.f
+incdir+include
rtl/core_types_pkg.sv
rtl/prf_bank_array.sv
rtl/alu_imm_compute.sv
rtl/alu_imm_pipeline.sv
rtl/alu_imm_subsystem.sv
tests/tb_alu_imm_subsystem.sv

//--- include/alu_imm_settings.svh
/*
  Sizes shared by the immediate ALU lane, its register file and the testbench.
  Include wherever a register, bank or ROB width is needed.
*/

`ifndef ALU_IMM_SETTINGS_SVH
`define ALU_IMM_SETTINGS_SVH

// Physical register file
`define PR_COUNT 64
`define LOG_PR_COUNT 6

// Banking, a register's bank is the low bits of its tag
`define PRF_BANK_COUNT 2
`define LOG_PRF_BANK_COUNT 1

// Reorder buffer
`define ROB_ENTRIES 16
`define LOG_ROB_ENTRIES 4

// Read requesters outside the lane, requester i owns port i of each bank
`define EXT_READERS 2

`endif

//--- rtl/alu_imm_compute.sv
/*
  Combinational datapath for the immediate ALU ops.
  The immediate is sign extended, shifts take its low 5 bits.
*/

`timescale 1ns/1ps
`default_nettype none

module alu_imm_compute import core_types_pkg::*; (
  input  alu_imm_op_t op,
  input  word_t       a,
  input  imm12_t      imm12,
  output word_t       result
);

  word_t      imm_sext;
  logic [4:0] shamt;

  assign imm_sext = {{20{imm12[11]}}, imm12};
  assign shamt    = imm12[4:0];

  always_comb begin
    case (op)
      ADDI:    result = a + imm_sext;
      SLTI:    result = {31'b0, ($signed(a) < $signed(imm_sext))};
      SLTIU:   result = {31'b0, (a < imm_sext)};
      XORI:    result = a ^ imm_sext;
      ORI:     result = a | imm_sext;
      ANDI:    result = a & imm_sext;
      SLLI:    result = a << shamt;
      SRLI:    result = a >> shamt;
      SRAI:    result = word_t'($signed(a) >>> shamt);
      // Unused encodings
      default: result = '0;
    endcase
  end

endmodule

`default_nettype wire

//--- rtl/alu_imm_pipeline.sv
/*
  Immediate ALU lane: operand collect, execute and writeback stages.
  A writeback stall freezes all three stages and blocks issue.
*/

`timescale 1ns/1ps
`default_nettype none

`include "alu_imm_settings.svh"

module alu_imm_pipeline import core_types_pkg::*; (
  input  logic                               CLK,
  input  logic                               nRST,
  input  logic                               issue_valid,
  input  alu_imm_op_t                        issue_op,
  input  imm12_t                             issue_imm12,
  input  pr_tag_t                            issue_A_PR,
  input  logic                               issue_A_forward,
  input  logic                               issue_A_is_zero,
  input  pr_tag_t                            issue_dest_PR,
  input  rob_index_t                         issue_ROB_index,
  output logic                               issue_ready,
  output logic                               A_read_req,
  output pr_tag_t                            A_read_PR,
  input  logic                               A_read_ack,
  input  logic                               A_read_port,
  input  word_t [`PRF_BANK_COUNT-1:0][1:0]   reg_read_data_by_bank_by_port,
  input  word_t [`PRF_BANK_COUNT-1:0]        forward_data_by_bank,
  input  logic                               WB_ready,
  output logic                               WB_valid,
  output word_t                              WB_data,
  output pr_tag_t                            WB_PR,
  output rob_index_t                         WB_ROB_index
);

  logic advance;
  logic read_needed;
  logic accept;

  // Operand collect stage
  logic        oc_valid;
  logic        oc_fresh;
  alu_imm_op_t oc_op;
  imm12_t      oc_imm12;
  logic        oc_A_forward;
  logic        oc_A_is_zero;
  bank_t       oc_A_bank;
  logic        oc_A_port;
  pr_tag_t     oc_dest_PR;
  rob_index_t  oc_ROB_index;
  word_t       oc_A_saved;
  word_t       rf_A;
  word_t       oc_A;
  word_t       oc_result;

  // Execute stage
  logic        ex_valid;
  word_t       ex_result;
  pr_tag_t     ex_dest_PR;
  rob_index_t  ex_ROB_index;

  // Everything moves unless writeback holds an item that is refused
  assign advance = !WB_valid || WB_ready;

  assign read_needed = issue_valid && !issue_A_is_zero && !issue_A_forward;
  assign A_read_req  = read_needed && advance;
  assign A_read_PR   = issue_A_PR;
  assign issue_ready = advance && (!read_needed || A_read_ack);
  assign accept      = issue_valid && issue_ready;

  always_ff @(posedge CLK or negedge nRST) begin
    if (!nRST) begin
      oc_valid <= 1'b0;
      oc_fresh <= 1'b0;
    end else begin
      oc_fresh <= advance;
      if (advance) begin
        oc_valid <= accept;
      end
    end
  end

  always_ff @(posedge CLK) begin
    if (advance) begin
      oc_op        <= issue_op;
      oc_imm12     <= issue_imm12;
      oc_A_forward <= issue_A_forward;
      oc_A_is_zero <= issue_A_is_zero;
      oc_A_bank    <= issue_A_PR[`LOG_PRF_BANK_COUNT-1:0];
      oc_A_port    <= A_read_port;
      oc_dest_PR   <= issue_dest_PR;
      oc_ROB_index <= issue_ROB_index;
    end
  end

  // Register file data is only valid in the first cycle in this stage,
  // so keep a copy for when a stall holds the operation here
  always_ff @(posedge CLK) begin
    if (oc_fresh) begin
      oc_A_saved <= rf_A;
    end
  end

  assign rf_A = oc_fresh ? reg_read_data_by_bank_by_port[oc_A_bank][oc_A_port] : oc_A_saved;

  always_comb begin
    if (oc_A_is_zero) begin
      oc_A = '0;
    end else if (oc_A_forward) begin
      oc_A = forward_data_by_bank[oc_A_bank];
    end else begin
      oc_A = rf_A;
    end
  end

  alu_imm_compute u_compute (
    .op     (oc_op),
    .a      (oc_A),
    .imm12  (oc_imm12),
    .result (oc_result)
  );

  always_ff @(posedge CLK or negedge nRST) begin
    if (!nRST) begin
      ex_valid <= 1'b0;
      WB_valid <= 1'b0;
    end else if (advance) begin
      ex_valid <= oc_valid;
      WB_valid <= ex_valid;
    end
  end

  always_ff @(posedge CLK) begin
    if (advance) begin
      ex_result    <= oc_result;
      ex_dest_PR   <= oc_dest_PR;
      ex_ROB_index <= oc_ROB_index;
      WB_data      <= ex_result;
      WB_PR        <= ex_dest_PR;
      WB_ROB_index <= ex_ROB_index;
    end
  end

endmodule

`default_nettype wire

//--- rtl/alu_imm_subsystem.sv
/*
  Top level of the immediate ALU lane with its banked register file.
  External readers share the file, writebacks leave through the WB ports.
*/

`timescale 1ns/1ps
`default_nettype none

`include "alu_imm_settings.svh"

module alu_imm_subsystem import core_types_pkg::*; (
  input  logic                        CLK,
  input  logic                        nRST,
  input  logic                        issue_valid,
  input  alu_imm_op_t                 issue_op,
  input  imm12_t                      issue_imm12,
  input  pr_tag_t                     issue_A_PR,
  input  logic                        issue_A_forward,
  input  logic                        issue_A_is_zero,
  input  pr_tag_t                     issue_dest_PR,
  input  rob_index_t                  issue_ROB_index,
  output logic                        issue_ready,
  input  logic [`EXT_READERS-1:0]     ext_read_valid,
  input  pr_tag_t [`EXT_READERS-1:0]  ext_read_PR,
  output word_t [`EXT_READERS-1:0]    ext_read_data,
  input  logic                        WB_ready,
  output logic                        WB_valid,
  output word_t                       WB_data,
  output pr_tag_t                     WB_PR,
  output rob_index_t                  WB_ROB_index
);

  logic                              A_read_req;
  pr_tag_t                           A_read_PR;
  logic                              A_read_ack;
  logic                              A_read_port;
  word_t [`PRF_BANK_COUNT-1:0][1:0]  reg_read_data_by_bank_by_port;
  word_t [`PRF_BANK_COUNT-1:0]       forward_data_by_bank;

  alu_imm_pipeline u_pipeline (
    .CLK                           (CLK),
    .nRST                          (nRST),
    .issue_valid                   (issue_valid),
    .issue_op                      (issue_op),
    .issue_imm12                   (issue_imm12),
    .issue_A_PR                    (issue_A_PR),
    .issue_A_forward               (issue_A_forward),
    .issue_A_is_zero               (issue_A_is_zero),
    .issue_dest_PR                 (issue_dest_PR),
    .issue_ROB_index               (issue_ROB_index),
    .issue_ready                   (issue_ready),
    .A_read_req                    (A_read_req),
    .A_read_PR                     (A_read_PR),
    .A_read_ack                    (A_read_ack),
    .A_read_port                   (A_read_port),
    .reg_read_data_by_bank_by_port (reg_read_data_by_bank_by_port),
    .forward_data_by_bank          (forward_data_by_bank),
    .WB_ready                      (WB_ready),
    .WB_valid                      (WB_valid),
    .WB_data                       (WB_data),
    .WB_PR                         (WB_PR),
    .WB_ROB_index                  (WB_ROB_index)
  );

  prf_bank_array u_prf (
    .CLK                           (CLK),
    .nRST                          (nRST),
    .ext_read_valid                (ext_read_valid),
    .ext_read_PR                   (ext_read_PR),
    .ext_read_data                 (ext_read_data),
    .A_read_req                    (A_read_req),
    .A_read_PR                     (A_read_PR),
    .A_read_ack                    (A_read_ack),
    .A_read_port                   (A_read_port),
    .reg_read_data_by_bank_by_port (reg_read_data_by_bank_by_port),
    .WB_valid                      (WB_valid),
    .WB_ready                      (WB_ready),
    .WB_PR                         (WB_PR),
    .WB_data                       (WB_data),
    .forward_data_by_bank          (forward_data_by_bank)
  );

endmodule

`default_nettype wire

//--- rtl/core_types_pkg.sv
/*
  Opcode and index types shared by the immediate ALU lane and its testbench.
  Modules pull these in with a wildcard import in their header.
*/

`default_nettype none

`include "alu_imm_settings.svh"

package core_types_pkg;

  // Immediate ALU opcodes, codes 9 to 15 are unused and give zero
  typedef enum logic [3:0] {
    ADDI  = 4'h0,
    SLTI  = 4'h1,
    SLTIU = 4'h2,
    XORI  = 4'h3,
    ORI   = 4'h4,
    ANDI  = 4'h5,
    SLLI  = 4'h6,
    SRLI  = 4'h7,
    SRAI  = 4'h8
  } alu_imm_op_t;

  typedef logic [31:0] word_t;

  typedef logic [`LOG_PR_COUNT-1:0] pr_tag_t;

  typedef logic [`LOG_PRF_BANK_COUNT-1:0] bank_t;

  typedef logic [`LOG_ROB_ENTRIES-1:0] rob_index_t;

  typedef logic [11:0] imm12_t;

endpackage

`default_nettype wire

//--- rtl/prf_bank_array.sv
/*
  Banked physical register file with two read ports per bank.
  External requesters own their port outright, the lane takes a leftover port.
  A completed writeback writes the array and drives the forward bus of its bank.
*/

`timescale 1ns/1ps
`default_nettype none

`include "alu_imm_settings.svh"

module prf_bank_array import core_types_pkg::*; (
  input  logic                                   CLK,
  input  logic                                   nRST,
  input  logic [`EXT_READERS-1:0]                ext_read_valid,
  input  pr_tag_t [`EXT_READERS-1:0]             ext_read_PR,
  output word_t [`EXT_READERS-1:0]               ext_read_data,
  input  logic                                   A_read_req,
  input  pr_tag_t                                A_read_PR,
  output logic                                   A_read_ack,
  output logic                                   A_read_port,
  output word_t [`PRF_BANK_COUNT-1:0][1:0]       reg_read_data_by_bank_by_port,
  input  logic                                   WB_valid,
  input  logic                                   WB_ready,
  input  pr_tag_t                                WB_PR,
  input  word_t                                  WB_data,
  output word_t [`PRF_BANK_COUNT-1:0]            forward_data_by_bank
);

  localparam int ROWS  = `PR_COUNT / `PRF_BANK_COUNT;
  localparam int ROW_W = `LOG_PR_COUNT - `LOG_PRF_BANK_COUNT;

  word_t regs [`PRF_BANK_COUNT][ROWS];

  logic                                    port0_free;
  logic                                    port1_free;
  bank_t                                   lane_bank;
  logic    [`PRF_BANK_COUNT-1:0][1:0]      port_en;
  pr_tag_t [`PRF_BANK_COUNT-1:0][1:0]      port_PR;
  bank_t   [`EXT_READERS-1:0]              ext_bank_q;
  logic                                    wb_fire;

  function automatic bank_t bank_of(input pr_tag_t pr);
    return pr[`LOG_PRF_BANK_COUNT-1:0];
  endfunction

  function automatic logic [ROW_W-1:0] row_of(input pr_tag_t pr);
    return pr[`LOG_PR_COUNT-1:`LOG_PRF_BANK_COUNT];
  endfunction

  // Lane arbitration, port 0 preferred
  assign lane_bank  = bank_of(A_read_PR);
  assign port0_free = !(ext_read_valid[0] && bank_of(ext_read_PR[0]) == lane_bank);
  assign port1_free = !(ext_read_valid[1] && bank_of(ext_read_PR[1]) == lane_bank);
  assign A_read_ack  = A_read_req && (port0_free || port1_free);
  assign A_read_port = !port0_free;

  // Tag seen by each bank port this cycle
  always_comb begin
    for (int b = 0; b < `PRF_BANK_COUNT; b++) begin
      for (int p = 0; p < `EXT_READERS; p++) begin
        port_en[b][p] = 1'b0;
        port_PR[b][p] = A_read_PR;
        if (ext_read_valid[p] && bank_of(ext_read_PR[p]) == bank_t'(b)) begin
          port_en[b][p] = 1'b1;
          port_PR[b][p] = ext_read_PR[p];
        end else if (A_read_ack && lane_bank == bank_t'(b) && A_read_port == p[0]) begin
          port_en[b][p] = 1'b1;
        end
      end
    end
  end

  // Registered read data, ready one cycle after the request
  always_ff @(posedge CLK) begin
    for (int b = 0; b < `PRF_BANK_COUNT; b++) begin
      for (int p = 0; p < `EXT_READERS; p++) begin
        if (port_en[b][p]) begin
          reg_read_data_by_bank_by_port[b][p] <= regs[b][row_of(port_PR[b][p])];
        end
      end
    end
  end

  always_ff @(posedge CLK) begin
    for (int i = 0; i < `EXT_READERS; i++) begin
      if (ext_read_valid[i]) begin
        ext_bank_q[i] <= bank_of(ext_read_PR[i]);
      end
    end
  end

  always_comb begin
    for (int i = 0; i < `EXT_READERS; i++) begin
      ext_read_data[i] = reg_read_data_by_bank_by_port[ext_bank_q[i]][i];
    end
  end

  assign wb_fire = WB_valid && WB_ready;

  // Write port, visible to reads requested from the next cycle on
  always_ff @(posedge CLK or negedge nRST) begin
    if (!nRST) begin
      for (int b = 0; b < `PRF_BANK_COUNT; b++) begin
        for (int r = 0; r < ROWS; r++) begin
          regs[b][r] <= '0;
        end
      end
    end else if (wb_fire) begin
      regs[bank_of(WB_PR)][row_of(WB_PR)] <= WB_data;
    end
  end

  // Forward bus carries the result only on its own bank
  always_comb begin
    for (int b = 0; b < `PRF_BANK_COUNT; b++) begin
      if (wb_fire && bank_of(WB_PR) == bank_t'(b)) begin
        forward_data_by_bank[b] = WB_data;
      end else begin
        forward_data_by_bank[b] = '0;
      end
    end
  end

endmodule

`default_nettype wire

//--- tests/tb_alu_imm_subsystem.sv
/*
  Testbench for the immediate ALU subsystem. Drives issue, external reads and
  WB_ready, predicts every writeback with a reference model and compares.
*/

`timescale 1ns/1ps
`default_nettype none

`include "alu_imm_settings.svh"

module tb_alu_imm_subsystem import core_types_pkg::*; ();

  // Far above the few hundred cycles the tests take with stalls
  localparam int TIMEOUT_CYCLES = 4000;

  logic                       CLK;
  logic                       nRST;
  logic                       issue_valid;
  alu_imm_op_t                issue_op;
  imm12_t                     issue_imm12;
  pr_tag_t                    issue_A_PR;
  logic                       issue_A_forward;
  logic                       issue_A_is_zero;
  pr_tag_t                    issue_dest_PR;
  rob_index_t                 issue_ROB_index;
  logic                       issue_ready;
  logic [`EXT_READERS-1:0]    ext_read_valid;
  pr_tag_t [`EXT_READERS-1:0] ext_read_PR;
  word_t [`EXT_READERS-1:0]   ext_read_data;
  logic                       WB_ready;
  logic                       WB_valid;
  word_t                      WB_data;
  pr_tag_t                    WB_PR;
  rob_index_t                 WB_ROB_index;

  // Reference model state
  word_t                   model_rf [`PR_COUNT];
  word_t                   exp_data_q [$];
  pr_tag_t                 exp_pr_q [$];
  rob_index_t              exp_rob_q [$];
  int                      exp_cycle_q [$];
  word_t                   exp_d;
  pr_tag_t                 exp_p;
  rob_index_t              exp_r;
  int                      exp_c;
  word_t                   hist_result [2];
  pr_tag_t                 hist_dest [2];
  logic [`EXT_READERS-1:0] ext_pending;
  word_t                   ext_expect [`EXT_READERS];
  logic                    prev_stalled;
  word_t                   held_data;
  pr_tag_t                 held_pr;
  rob_index_t              held_rob;
  word_t                   a_val;
  word_t                   new_result;
  logic                    new_accept;

  string       test_name;
  logic        stall_mode;
  logic        latency_on;
  rob_index_t  rob_next;
  int          cycle = 0;
  int          errors;
  int          errors_at_start;
  int          tests_run;
  int          tests_failed;

  alu_imm_subsystem u_alu_imm_subsystem (.*);

  initial begin
    CLK = 1'b0;
    forever #10 CLK = ~CLK;
  end

  function automatic word_t ref_alu_imm(input logic [3:0] op, input word_t a,
                                        input imm12_t imm);
    word_t sext;
    sext = {{20{imm[11]}}, imm};
    case (op)
      ADDI:    return a + sext;
      SLTI:    return ($signed(a) < $signed(sext)) ? 32'd1 : 32'd0;
      SLTIU:   return (a < sext) ? 32'd1 : 32'd0;
      XORI:    return a ^ sext;
      ORI:     return a | sext;
      ANDI:    return a & sext;
      SLLI:    return a << imm[4:0];
      SRLI:    return a >> imm[4:0];
      SRAI:    return $signed(a) >>> imm[4:0];
      default: return 32'd0;
    endcase
  endfunction

  task automatic check_value(input string what, input logic [31:0] expected,
                             input logic [31:0] actual);
    if (expected !== actual) begin
      $display("MISMATCH %s %s expected %h actual %h", test_name, what, expected, actual);
      errors++;
    end
  endtask

  task automatic drive_issue(input logic [3:0] op, input imm12_t imm, input pr_tag_t a_pr,
                             input logic fwd, input logic zero, input pr_tag_t dest);
    issue_valid     <= 1'b1;
    issue_op        <= alu_imm_op_t'(op);
    issue_imm12     <= imm;
    issue_A_PR      <= a_pr;
    issue_A_forward <= fwd;
    issue_A_is_zero <= zero;
    issue_dest_PR   <= dest;
    issue_ROB_index <= rob_next;
    rob_next = rob_next + 1'b1;
  endtask

  task automatic wait_accept();
    @(posedge CLK);
    while (!issue_ready) begin
      @(posedge CLK);
    end
  endtask

  task automatic send(input logic [3:0] op, input imm12_t imm, input pr_tag_t a_pr,
                      input logic fwd, input logic zero, input pr_tag_t dest);
    drive_issue(op, imm, a_pr, fwd, zero, dest);
    wait_accept();
  endtask

  task automatic idle();
    issue_valid <= 1'b0;
  endtask

  task automatic begin_test(input string name, input logic stall, input logic latency);
    @(negedge CLK);
    test_name       = name;
    stall_mode      = stall;
    latency_on      = latency;
    errors_at_start = errors;
    @(posedge CLK);
  endtask

  task automatic end_test();
    @(negedge CLK);
    while (exp_data_q.size() != 0) begin
      @(negedge CLK);
    end
    // Idle cycles so a duplicated writeback would still be caught
    repeat (4) @(negedge CLK);
    tests_run++;
    if (errors == errors_at_start) begin
      $display("Test %s passed", test_name);
    end else begin
      tests_failed++;
      $display("Test %s failed with %0d errors", test_name, errors - errors_at_start);
    end
  endtask

  task automatic measure_latency();
    begin_test("latency", 1'b0, 1'b1);
    send(ADDI, 12'h7ff, '0, 1'b0, 1'b1, 6'd5);
    idle();
    repeat (5) @(posedge CLK);
    send(ORI, 12'h8a5, '0, 1'b0, 1'b1, 6'd6);
    idle();
    end_test();
  endtask

  task automatic exercise_opcodes();
    logic [31:0] rnd;
    begin_test("opcodes", 1'b0, 1'b1);
    for (int r = 0; r < 16; r++) begin
      rnd = $urandom;
      send(ADDI, rnd[11:0], '0, 1'b0, 1'b1, pr_tag_t'(r));
    end
    // A comes from the registers just written
    for (int k = 0; k < 48; k++) begin
      rnd = $urandom;
      send(rnd[3:0], rnd[15:4], {2'b00, rnd[19:16]}, 1'b0, 1'b0, {1'b0, rnd[25:21]});
    end
    idle();
    end_test();
  endtask

  task automatic forward_results();
    logic [31:0] rnd;
    begin_test("forwarding", 1'b0, 1'b1);
    // From the third op on, A is the result of the op two issues back
    for (int k = 0; k < 12; k++) begin
      rnd = $urandom;
      send({1'b0, rnd[2:0]}, rnd[15:4], pr_tag_t'(30 + k), k >= 2, k < 2, pr_tag_t'(32 + k));
    end
    idle();
    end_test();
  endtask

  task automatic stall_writeback();
    logic [31:0] rnd;
    begin_test("stall", 1'b1, 1'b0);
    for (int k = 0; k < 40; k++) begin
      rnd = $urandom;
      send(rnd[3:0], rnd[15:4], rnd[21:16], 1'b0, rnd[23:22] == 2'b00, rnd[29:24]);
    end
    idle();
    end_test();
  endtask

  task automatic contend_reads();
    logic [31:0] rnd;
    begin_test("contention", 1'b0, 1'b0);
    send(ADDI, 12'h5a5, '0, 1'b0, 1'b1, 6'd7);
    // Registers 7, 9 and 11 all live in bank 1
    ext_read_PR[0] <= 6'd9;
    ext_read_PR[1] <= 6'd11;
    ext_read_valid <= 2'b11;
    drive_issue(ADDI, 12'h001, 6'd7, 1'b0, 1'b0, 6'd40);
    repeat (4) begin
      @(posedge CLK);
      check_value("issue_ready with both ports taken", 32'd0, issue_ready);
    end
    // Requester 0 keeps port 0, so the lane reads through port 1
    ext_read_valid <= 2'b01;
    wait_accept();
    idle();
    repeat (12) begin
      rnd = $urandom;
      ext_read_valid <= rnd[1:0];
      ext_read_PR[0] <= rnd[7:2];
      ext_read_PR[1] <= rnd[13:8];
      @(posedge CLK);
    end
    ext_read_valid <= 2'b00;
    end_test();
  endtask

  task automatic reset_midflight();
    begin_test("reset", 1'b0, 1'b0);
    send(ADDI, 12'h123, '0, 1'b0, 1'b1, 6'd10);
    send(XORI, 12'hfff, '0, 1'b0, 1'b1, 6'd12);
    idle();
    nRST <= 1'b0;
    repeat (2) @(posedge CLK);
    nRST <= 1'b1;
    @(posedge CLK);
    check_value("WB_valid after reset", 32'd0, WB_valid);
    check_value("issue_ready after reset", 32'd1, issue_ready);
    // Register 33 reads back as zero now
    send(ORI, 12'h0f0, 6'd33, 1'b0, 1'b0, 6'd34);
    idle();
    end_test();
  endtask

  always @(posedge CLK) begin
    if (stall_mode) begin
      WB_ready <= ($urandom % 4) != 0;
    end else begin
      WB_ready <= 1'b1;
    end
  end

  // Prediction and comparison on values from before the edge
  always @(posedge CLK) begin
    if (!nRST) begin
      for (int r = 0; r < `PR_COUNT; r++) begin
        model_rf[r] = '0;
      end
      exp_data_q.delete();
      exp_pr_q.delete();
      exp_rob_q.delete();
      exp_cycle_q.delete();
      hist_result[0] = '0;
      hist_result[1] = '0;
      hist_dest[0]   = '0;
      hist_dest[1]   = '0;
      ext_pending    = '0;
      prev_stalled   = 1'b0;
    end else begin
      for (int i = 0; i < `EXT_READERS; i++) begin
        if (ext_pending[i]) begin
          check_value("ext_read_data", ext_expect[i], ext_read_data[i]);
        end
        ext_pending[i] = ext_read_valid[i];
        ext_expect[i]  = model_rf[ext_read_PR[i]];
      end
      if (prev_stalled) begin
        check_value("WB_valid held", 32'd1, WB_valid);
        check_value("WB_data held", held_data, WB_data);
        check_value("WB_PR held", held_pr, WB_PR);
        check_value("WB_ROB_index held", held_rob, WB_ROB_index);
      end
      prev_stalled = WB_valid && !WB_ready;
      held_data    = WB_data;
      held_pr      = WB_PR;
      held_rob     = WB_ROB_index;
      // Operand read sees the register file before this edge's write
      new_accept = issue_valid && issue_ready;
      if (issue_A_is_zero) begin
        a_val = '0;
      end else if (issue_A_forward) begin
        a_val = (hist_dest[1][0] == issue_A_PR[0]) ? hist_result[1] : '0;
      end else begin
        a_val = model_rf[issue_A_PR];
      end
      new_result = ref_alu_imm(issue_op, a_val, issue_imm12);
      if (WB_valid && WB_ready) begin
        if (exp_data_q.size() == 0) begin
          $display("Unexpected writeback in %s to register %0d", test_name, WB_PR);
          errors++;
        end else begin
          exp_d = exp_data_q.pop_front();
          exp_p = exp_pr_q.pop_front();
          exp_r = exp_rob_q.pop_front();
          exp_c = exp_cycle_q.pop_front();
          check_value("WB_data", exp_d, WB_data);
          check_value("WB_PR", exp_p, WB_PR);
          check_value("WB_ROB_index", exp_r, WB_ROB_index);
          if (latency_on) begin
            check_value("latency", 32'd3, cycle - exp_c);
          end
          model_rf[exp_p] = exp_d;
        end
      end
      if (new_accept) begin
        exp_data_q.push_back(new_result);
        exp_pr_q.push_back(issue_dest_PR);
        exp_rob_q.push_back(issue_ROB_index);
        exp_cycle_q.push_back(cycle);
        hist_result[1] = hist_result[0];
        hist_dest[1]   = hist_dest[0];
        hist_result[0] = new_result;
        hist_dest[0]   = issue_dest_PR;
      end
    end
    cycle++;
  end

  initial begin
    wait (cycle >= TIMEOUT_CYCLES);
    $display("Timeout, the tests did not finish within %0d cycles", TIMEOUT_CYCLES);
    $display("SOME TESTS FAILED");
    $finish;
  end

  initial begin
    void'($urandom(32'h35a0_b41a));
    nRST            <= 1'b0;
    issue_valid     <= 1'b0;
    issue_op        <= ADDI;
    issue_imm12     <= '0;
    issue_A_PR      <= '0;
    issue_A_forward <= 1'b0;
    issue_A_is_zero <= 1'b0;
    issue_dest_PR   <= '0;
    issue_ROB_index <= '0;
    ext_read_valid  <= '0;
    ext_read_PR     <= '0;
    WB_ready        <= 1'b1;
    stall_mode      = 1'b0;
    latency_on      = 1'b0;
    rob_next        = '0;
    errors          = 0;
    tests_run       = 0;
    tests_failed    = 0;
    test_name       = "startup";
    repeat (2) @(posedge CLK);
    nRST <= 1'b1;
    measure_latency();
    exercise_opcodes();
    forward_results();
    stall_writeback();
    contend_reads();
    reset_midflight();
    $display("%0d tests run, %0d failed, %0d errors", tests_run, tests_failed, errors);
    if (errors == 0) begin
      $display("ALL TESTS PASSED");
    end else begin
      $display("SOME TESTS FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire
